// ==== free_list.sv ====
// ==========================================================
// free physical register list, circular FIFO
// multi-lane push, single pop, preloaded at reset
// ==========================================================

module free_list (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [rename_pkg::NUM_COMMITS-1:0]  push,
	input  logic [rename_pkg::PHYS_REG_W-1:0]   push_id [rename_pkg::NUM_COMMITS],
	input  logic                                pop,
	output logic [rename_pkg::PHYS_REG_W-1:0]   pop_id,
	output logic                                empty,
	output logic                                next_empty
);

	import rename_pkg::*;

	// storage, one slot per physical register
	logic [PHYS_REG_W-1:0] fifo_mem [NUM_PHYS];

	logic [PHYS_REG_W-1:0] head;	// oldest free entry
	logic [PHYS_REG_W-1:0] tail;	// next slot to write
	logic [FL_CNT_W-1:0]   count;	// entries held
	logic [FL_CNT_W-1:0]   count_next;

	logic [FL_CNT_W-1:0]   push_cnt;	// active push lanes this cycle
	logic [PHYS_REG_W-1:0] wr_slot [NUM_COMMITS];	// target slot per lane
	logic                  do_pop;

	// lanes pack into consecutive slots, lane 0 first
	always_comb begin
		push_cnt = '0;
		for (int i = 0; i < NUM_COMMITS; i++) begin
			wr_slot[i] = tail + push_cnt[PHYS_REG_W-1:0];	// skips idle lanes
			if (push[i]) begin
				push_cnt = push_cnt + 1'b1;
			end
		end
	end

	// never pop past the last entry
	assign do_pop = pop & ~empty;

	assign count_next = count + push_cnt - FL_CNT_W'(do_pop);

	assign empty      = (count == '0);
	assign next_empty = (count_next == '0);	// state after this edge

	// head entry always visible, popped or not
	assign pop_id = fifo_mem[head];

	// memory, preload wraps so slots 0..47 hold 16..63
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_PHYS; i++) begin
				fifo_mem[i] <= PHYS_REG_W'(NUM_ARCH + i);
			end
		end else begin
			for (int i = 0; i < NUM_COMMITS; i++) begin
				if (push[i]) begin
					fifo_mem[wr_slot[i]] <= push_id[i];
				end
			end
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head  <= '0;
			tail  <= PHYS_REG_W'(NUM_FREE_INIT);	// first slot past the preload
			count <= FL_CNT_W'(NUM_FREE_INIT);
		end else begin
			head  <= head + PHYS_REG_W'(do_pop);	// wraps at NUM_PHYS
			tail  <= tail + push_cnt[PHYS_REG_W-1:0];
			count <= count_next;
		end
	end

endmodule

// ==== rename_map.sv ====
// ==========================================================
// architectural to physical map table, old-mapping table
// rename decode, free list pop and commit release
// ==========================================================

module rename_map (
	input  logic                                clk,
	input  logic                                reset,
	input  rename_pkg::rename_req_t             req,
	input  rename_pkg::commit_t                 commit [rename_pkg::NUM_COMMITS],
	input  logic [rename_pkg::PHYS_REG_W-1:0]   pop_id,
	input  logic                                empty,
	input  logic                                next_empty,
	output logic                                pop,
	output logic [rename_pkg::NUM_COMMITS-1:0]  push,
	output logic [rename_pkg::PHYS_REG_W-1:0]   push_id [rename_pkg::NUM_COMMITS],
	output rename_pkg::rename_rsp_t             rsp,
	output logic                                can_rename
);

	import rename_pkg::*;

	// current mapping per architectural register
	logic [PHYS_REG_W-1:0] map_q [NUM_ARCH];

	// per physical reg, the mapping it displaced when allocated
	old_map_t old_q [NUM_PHYS];

	old_map_t commit_old [NUM_COMMITS];	// old entry looked up per lane
	logic     wants_write;	// valid request with a destination

	assign wants_write = req.valid & req.regwrite;

	// allocate only with a register at the head
	assign pop = wants_write & ~empty;

	// writing request on an empty list is dropped
	always_comb begin
		rsp.valid     = req.valid & ~(req.regwrite & empty);
		rsp.phys_src1 = map_q[req.src1];	// map before this cycle's write
		rsp.phys_src2 = map_q[req.src2];
		rsp.phys_dst  = req.regwrite ? pop_id : map_q[req.dst];
	end

	// commit lanes, release the displaced register
	always_comb begin
		for (int i = 0; i < NUM_COMMITS; i++) begin
			commit_old[i] = old_q[commit[i].phys_reg];
			push_id[i]    = commit_old[i].old_phys;
			push[i]       = commit[i].valid & commit[i].with_write & commit_old[i].has_old;
			// a reg released by an earlier lane is already cleared
			for (int j = 0; j < i; j++) begin
				if (push[j] && (commit[j].phys_reg == commit[i].phys_reg)) begin
					push[i] = 1'b0;
				end
			end
		end
	end

	// next cycle may take a writing request
	assign can_rename = ~next_empty;

	// map table, identity out of reset
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int a = 0; a < NUM_ARCH; a++) begin
				map_q[a] <= PHYS_REG_W'(a);
			end
		end else if (pop) begin
			map_q[req.dst] <= pop_id;	// new producer of dst
		end
	end

	// old-mapping table
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < NUM_PHYS; p++) begin
				old_q[p] <= '0;	// nothing displaced yet
			end
		end else begin
			for (int i = 0; i < NUM_COMMITS; i++) begin
				if (push[i]) begin
					old_q[commit[i].phys_reg].has_old <= 1'b0;
				end
			end
			// allocation last, wins over a clear of the same entry
			if (pop) begin
				old_q[pop_id] <= '{has_old: 1'b1, old_phys: map_q[req.dst]};
			end
		end
	end

endmodule

// ==== rename_pkg.sv ====
// ==========================================================
// register counts and struct types shared by the rename block
// ==========================================================

package rename_pkg;

	localparam int ARCH_REG_W  = 4;	// 16 architectural registers
	localparam int PHYS_REG_W  = 6;	// 64 physical registers
	localparam int NUM_ARCH    = 1 << ARCH_REG_W;
	localparam int NUM_PHYS    = 1 << PHYS_REG_W;
	localparam int NUM_COMMITS = 2;	// commit lanes per cycle

	// free list sizing
	localparam int NUM_FREE_INIT = NUM_PHYS - NUM_ARCH;	// regs free out of reset
	localparam int FL_CNT_W      = PHYS_REG_W + 1;	// count reaches NUM_PHYS

	// one instruction into rename
	typedef struct packed {
		logic                  valid;
		logic                  regwrite;	// instruction has a destination
		logic [ARCH_REG_W-1:0] src1;
		logic [ARCH_REG_W-1:0] src2;
		logic [ARCH_REG_W-1:0] dst;
	} rename_req_t;

	// renamed operands, same cycle as the request
	typedef struct packed {
		logic                  valid;
		logic [PHYS_REG_W-1:0] phys_src1;
		logic [PHYS_REG_W-1:0] phys_src2;
		logic [PHYS_REG_W-1:0] phys_dst;
	} rename_rsp_t;

	// one commit lane
	typedef struct packed {
		logic                  valid;
		logic                  with_write;
		logic [PHYS_REG_W-1:0] phys_reg;	// dst given at rename
	} commit_t;

	// mapping displaced by an allocation, freed at commit
	typedef struct packed {
		logic                  has_old;
		logic [PHYS_REG_W-1:0] old_phys;
	} old_map_t;

endpackage

// ==== rename_unit.sv ====
// ==========================================================
// rename unit top, map table joined to the free list
// ==========================================================

module rename_unit (
	input  logic                     clk,
	input  logic                     reset,
	input  rename_pkg::rename_req_t  req,
	input  rename_pkg::commit_t      commit [rename_pkg::NUM_COMMITS],
	output rename_pkg::rename_rsp_t  rsp,
	output logic                     can_rename
);

	import rename_pkg::*;

	// free list handshake, map side drives pop and push
	logic                   pop;
	logic [PHYS_REG_W-1:0]  pop_id;	// head of the list
	logic                   empty;
	logic                   next_empty;
	logic [NUM_COMMITS-1:0] push;
	logic [PHYS_REG_W-1:0]  push_id [NUM_COMMITS];	// released regs per lane

	rename_map u_map (
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.commit     (commit),
		.pop_id     (pop_id),
		.empty      (empty),
		.next_empty (next_empty),
		.pop        (pop),
		.push       (push),
		.push_id    (push_id),
		.rsp        (rsp),
		.can_rename (can_rename)
	);

	// 64-entry list, holds 16..63 after reset
	free_list u_free_list (
		.clk        (clk),
		.reset      (reset),
		.push       (push),
		.push_id    (push_id),
		.pop        (pop),
		.pop_id     (pop_id),
		.empty      (empty),
		.next_empty (next_empty)
	);

endmodule

// ==== rename_unit_asserts.sv ====
// ==========================================================
// concurrent assertions on free list pop/push and old map
// ==========================================================

module rename_unit_asserts (
	input logic                                clk,
	input logic                                reset,
	input logic                                pop,
	input logic                                empty,
	input logic [rename_pkg::NUM_COMMITS-1:0]  push,
	input logic [rename_pkg::PHYS_REG_W-1:0]   pop_id,
	input rename_pkg::old_map_t                old_q [rename_pkg::NUM_PHYS]
);

	import rename_pkg::*;

	int fail_cnt = 0;	// assertion failures so far

	// allocation only from a non-empty list
	pop_needs_entry: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else begin
			fail_cnt++;
			$error("pop issued while the free list is empty");
		end

	// nothing released while reset is held
	no_push_in_reset: assert property (@(posedge clk) reset |-> (push == '0))
		else begin
			fail_cnt++;
			$error("push lane active during reset");
		end

	// a free register carries no pending displaced mapping
	free_head_clean: assert property (@(posedge clk) disable iff (reset)
		pop |-> !old_q[pop_id].has_old)
		else begin
			fail_cnt++;
			$error("popped register still holds an old mapping");
		end

endmodule

// ==== tb_rename_unit.sv ====
// ==========================================================
// rename unit testbench, LFSR stimulus and reference model
// identity reads, allocation order, commits, back-pressure, mix
// ==========================================================

module tb_rename_unit;

	import rename_pkg::*;

	logic        clk;
	logic        reset;
	rename_req_t req;
	commit_t     commit [NUM_COMMITS];
	rename_rsp_t rsp;
	logic        can_rename;

	// reference model state
	logic [PHYS_REG_W-1:0] m_map [NUM_ARCH];
	old_map_t              m_old [NUM_PHYS];
	logic [PHYS_REG_W-1:0] m_free [$];	// head first
	logic [PHYS_REG_W-1:0] inflight [$];	// allocated, not committed yet
	logic                  exp_can;	// can_rename expected last cycle

	logic [31:0] lfsr;
	rename_rsp_t seen_rsp;	// rsp sampled in the last cycle
	string       cur_test;
	int          checks;
	int          errs;
	int          test_checks;
	int          test_errs;
	int          tests_run;
	int          cycle_cnt;

	rename_unit u_dut (
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.commit     (commit),
		.rsp        (rsp),
		.can_rename (can_rename)
	);

	bind rename_map rename_unit_asserts u_asserts (
		.clk    (clk),
		.reset  (reset),
		.pop    (pop),
		.empty  (empty),
		.push   (push),
		.pop_id (pop_id),
		.old_q  (old_q)
	);

	always #10 clk = ~clk;	// period 20

	// run limit, all tests together take about 1.8k cycles
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= 5000) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	// galois lfsr, taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_checks = 0;
		test_errs   = 0;
	endtask

	task automatic report_test();
		tests_run++;
		$display("%-16s %0d checks, %0d errors", cur_test, test_checks, test_errs);
	endtask

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		test_checks++;
		assert (act === exp)
		else begin
			$display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			errs++;
			test_errs++;
		end
	endtask

	// state right after reset
	task automatic model_reset();
		for (int a = 0; a < NUM_ARCH; a++) begin
			m_map[a] = PHYS_REG_W'(a);
		end
		for (int p = 0; p < NUM_PHYS; p++) begin
			m_old[p] = '0;
		end
		m_free.delete();
		for (int p = NUM_ARCH; p < NUM_PHYS; p++) begin
			m_free.push_back(PHYS_REG_W'(p));
		end
		inflight.delete();
		exp_can = 1'b1;
	endtask

	// random sources and destination, strobes left low
	task automatic rand_regs(output rename_req_t r);
		logic [31:0] v;
		get_bits(3 * ARCH_REG_W, v);
		r      = '0;
		r.src1 = v[ARCH_REG_W-1:0];
		r.src2 = v[2*ARCH_REG_W-1:ARCH_REG_W];
		r.dst  = v[3*ARCH_REG_W-1:2*ARCH_REG_W];
	endtask

	// commit lane, writing commits follow allocation order
	task automatic make_lane(input logic en, input logic ww, input logic [PHYS_REG_W-1:0] rnd,
		output commit_t c);
		c = '0;
		if (en && !ww) begin
			c.valid    = 1'b1;	// instruction without a destination
			c.phys_reg = rnd;
		end else if (en && inflight.size() > 0) begin
			c.valid      = 1'b1;
			c.with_write = 1'b1;
			c.phys_reg   = inflight.pop_front();
		end
	endtask

	// drive one cycle, check rsp and can_rename, step the model
	task automatic run_cycle(input rename_req_t r, input commit_t c0, input commit_t c1);
		commit_t               cl [NUM_COMMITS];
		logic                  m_empty;
		logic                  exp_valid;
		logic                  do_pop;
		logic [NUM_COMMITS-1:0] exp_push;
		logic [PHYS_REG_W-1:0] rel_id [NUM_COMMITS];
		logic [PHYS_REG_W-1:0] new_id;
		int                    next_cnt;
		@(posedge clk);
		#2;
		req       = r;
		commit[0] = c0;
		commit[1] = c1;
		cl[0]     = c0;
		cl[1]     = c1;
		m_empty   = (m_free.size() == 0);
		exp_valid = r.valid & ~(r.regwrite & m_empty);	// write on empty list dropped
		do_pop    = r.valid & r.regwrite & ~m_empty;
		for (int i = 0; i < NUM_COMMITS; i++) begin
			exp_push[i] = cl[i].valid & cl[i].with_write & m_old[cl[i].phys_reg].has_old;
			rel_id[i]   = m_old[cl[i].phys_reg].old_phys;
			for (int j = 0; j < i; j++) begin
				if (exp_push[j] && cl[j].phys_reg == cl[i].phys_reg) begin
					exp_push[i] = 1'b0;	// cleared by the earlier lane
				end
			end
		end
		next_cnt = m_free.size() - int'(do_pop);
		for (int i = 0; i < NUM_COMMITS; i++) begin
			next_cnt += int'(exp_push[i]);
		end
		#8;	// sample mid cycle
		seen_rsp = rsp;
		check_val("rsp.valid", exp_valid, rsp.valid);
		if (exp_valid) begin
			check_val("phys_src1", m_map[r.src1], rsp.phys_src1);
			check_val("phys_src2", m_map[r.src2], rsp.phys_src2);
			check_val("phys_dst", r.regwrite ? m_free[0] : m_map[r.dst], rsp.phys_dst);
		end
		check_val("can_rename", next_cnt != 0, can_rename);
		// model follows the coming edge
		for (int i = 0; i < NUM_COMMITS; i++) begin
			if (exp_push[i]) begin
				m_old[cl[i].phys_reg].has_old = 1'b0;
			end
		end
		if (do_pop) begin
			new_id        = m_free.pop_front();
			m_old[new_id] = '{has_old: 1'b1, old_phys: m_map[r.dst]};
			m_map[r.dst]  = new_id;
			inflight.push_back(new_id);
		end
		for (int i = 0; i < NUM_COMMITS; i++) begin
			if (exp_push[i]) begin
				m_free.push_back(rel_id[i]);	// lane 0 first
			end
		end
		exp_can = (next_cnt != 0);
	endtask

	initial begin
		rename_req_t           r;
		commit_t               c0;
		commit_t               c1;
		logic [31:0]           bits;
		logic [31:0]           rnd;
		logic [ARCH_REG_W-1:0] held_dst;
		int                    n;
		clk       = 1'b0;
		reset     = 1'b1;
		req       = '0;
		commit[0] = '0;
		commit[1] = '0;
		lfsr      = 32'h8f3c;
		checks    = 0;
		errs      = 0;
		tests_run = 0;
		cycle_cnt = 0;
		model_reset();
		@(posedge clk);
		#2;
		// live commit strobes under reset, none may reach the list
		commit[0] = '{valid: 1'b1, with_write: 1'b1, phys_reg: PHYS_REG_W'(NUM_ARCH)};
		commit[1] = '{valid: 1'b1, with_write: 1'b1, phys_reg: PHYS_REG_W'(NUM_ARCH + 1)};
		repeat (9) @(posedge clk);
		#2;
		reset     = 1'b0;
		commit[0] = '0;
		commit[1] = '0;

		begin_test("reset_state");
		run_cycle('0, '0, '0);
		check_val("idle rsp.valid", 0, seen_rsp.valid);
		check_val("can_rename", 1, can_rename);
		report_test();

		// reads only, identity map
		begin_test("identity_read");
		for (int i = 0; i < NUM_ARCH; i++) begin
			r = '{valid: 1'b1, regwrite: 1'b0, src1: ARCH_REG_W'(i),
				src2: ARCH_REG_W'(NUM_ARCH - 1 - i), dst: ARCH_REG_W'(i)};
			run_cycle(r, '0, '0);
			check_val("identity src1", i, seen_rsp.phys_src1);
			check_val("identity src2", NUM_ARCH - 1 - i, seen_rsp.phys_src2);
			check_val("can_rename", 1, can_rename);
		end
		report_test();

		begin_test("alloc_order");
		for (int i = 0; i < 24; i++) begin
			rand_regs(r);
			r.valid    = 1'b1;
			r.regwrite = 1'b1;
			run_cycle(r, '0, '0);
			if (i == 0) begin
				check_val("first phys_dst", NUM_ARCH, seen_rsp.phys_dst);
			end
		end
		for (int i = 0; i < 16; i++) begin
			rand_regs(r);
			r.valid = 1'b1;	// later reads see the new map
			run_cycle(r, '0, '0);
		end
		report_test();

		begin_test("commit_release");
		// identity regs have no old mapping yet, nothing freed
		for (int i = 0; i < 4; i++) begin
			get_bits(ARCH_REG_W, bits);
			c0 = '{valid: 1'b1, with_write: 1'b1, phys_reg: PHYS_REG_W'(bits[ARCH_REG_W-1:0])};
			run_cycle('0, c0, '0);
		end
		for (int i = 0; i < 80; i++) begin
			get_bits(4, bits);
			make_lane(bits[0], 1'b1, '0, c0);
			make_lane(bits[1], 1'b1, '0, c1);	// both lanes about 1 in 4
			rand_regs(r);
			r.valid    = 1'b1;
			r.regwrite = (bits[2] | bits[3]) & exp_can;	// source holds writes
			run_cycle(r, c0, c1);
		end
		report_test();

		// drain the list without commits
		begin_test("backpressure");
		n = 0;
		while (m_free.size() > 0 && n < 48) begin
			rand_regs(r);
			r.valid    = 1'b1;
			r.regwrite = 1'b1;
			run_cycle(r, '0, '0);
			n++;
		end
		check_val("can_rename low", 0, can_rename);
		rand_regs(r);
		r.valid    = 1'b1;
		r.regwrite = 1'b1;
		held_dst   = r.dst;
		run_cycle(r, '0, '0);	// sent anyway
		check_val("dropped rsp.valid", 0, seen_rsp.valid);
		r = '{valid: 1'b1, regwrite: 1'b0, src1: held_dst, src2: held_dst, dst: held_dst};
		run_cycle(r, '0, '0);	// map unchanged by the drop
		report_test();

		begin_test("random_mix");
		for (int i = 0; i < 1500; i++) begin
			get_bits(10, bits);
			get_bits(PHYS_REG_W, rnd);
			make_lane(bits[3] & bits[4], bits[5] | bits[9], rnd[PHYS_REG_W-1:0], c0);
			make_lane(bits[6] & bits[7], bits[8] | bits[9], ~rnd[PHYS_REG_W-1:0], c1);
			rand_regs(r);
			r.valid    = bits[0];
			r.regwrite = (bits[1] | bits[2]) & exp_can;
			run_cycle(r, c0, c1);
		end
		report_test();

		if (u_dut.u_map.u_asserts.fail_cnt != 0) begin
			$display("concurrent assertions failed %0d times", u_dut.u_map.u_asserts.fail_cnt);
			errs += u_dut.u_map.u_asserts.fail_cnt;
		end
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errs);
		if (errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
rename_pkg.sv
free_list.sv
rename_map.sv
rename_unit.sv
rename_unit_asserts.sv
tb_rename_unit.sv
